/* verilog.f */
rtl/rv_core_pkg.sv
rtl/rv_alu.sv
rtl/rv_imm_gen.sv
rtl/rv_regfile.sv
rtl/rv_pc_unit.sv
rtl/rv_decoder.sv
rtl/rv_core.sv
testbench/tb_clock_gen.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_core_tb -f verilog.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
    echo "Testbench reported a failure, see $log"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $log"
    exit 1
fi

exit 0

/* testbench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int drive_delay = 10;
    localparam int period_ns   = 100;
    localparam int random_ops  = 300;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] rd_data;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic        wr_en;

    logic [31:0] prog [$];
    logic [31:0] lfsr_state = 32'hd8210ef2;
    logic [31:0] dmem [16];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [16];
    logic [31:0] ref_pc;
    logic        running = 1'b0;
    logic        prog_ready = 1'b0;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    rv_core UUT (
        .clk(clk), .reset(reset), .instr(instr), .rd_data(rd_data),
        .pc(pc), .addr(addr), .wr_data(wr_data), .wr_en(wr_en)
    );

    bind rv_core rv_core_assert core_checks (
        .clk(clk), .reset(reset), .pc(pc), .addr(addr), .wr_en(wr_en)
    );

    // Data memory of 16 words read in the same cycle
    always_comb begin
        // Registers hold nothing known before the first writes
        if ($isunknown(addr)) begin
            rd_data = '0;
        end else begin
            rd_data = dmem[addr[5:2]];
        end
    end

    always @(posedge clk) begin
        if (wr_en) begin
            dmem[addr[5:2]] <= wr_data;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Word store of src to a random aligned offset from x0
    function automatic logic [31:0] store_of(input logic [4:0] src);
        logic [31:0] off;
        off = random_bits(10) << 2;
        return {off[11:5], src, 5'd0, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Executes one instruction on the model state
    function automatic void execute_ref(input logic [31:0] w, output logic [31:0] exp_pc,
                                        output logic exp_mem, output logic exp_we,
                                        output logic [31:0] exp_addr,
                                        output logic [31:0] exp_wdata);
        logic [31:0] a, b, i_imm, s_imm, b_imm, j_imm;
        logic [31:0] res, tgt, next_pc;
        logic [2:0]  f3;
        logic        wr_rd;
        logic        taken;
        f3 = w[14:12];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        exp_pc = ref_pc;
        exp_mem = 1'b0;
        exp_we = 1'b0;
        exp_addr = '0;
        exp_wdata = '0;
        res = '0;
        tgt = '0;
        wr_rd = 1'b0;
        taken = 1'b0;
        next_pc = ref_pc + 32'd4;
        case (w[6:0])
            7'b0110011: begin
                res = alu_model(f3, w[30], a, b);
                wr_rd = 1'b1;
            end
            7'b0010011: begin
                res = alu_model(f3, w[30] && f3 == 3'b101, a, i_imm);
                wr_rd = 1'b1;
            end
            7'b0110111: begin
                res = {w[31:12], 12'b0};
                wr_rd = 1'b1;
            end
            7'b0010111: begin
                res = ref_pc + {w[31:12], 12'b0};
                wr_rd = 1'b1;
            end
            7'b0000011: begin
                if (f3 == 3'b010) begin
                    exp_mem = 1'b1;
                    exp_addr = a + i_imm;
                    if (exp_addr[1:0] == 2'b00) begin
                        res = ref_mem[exp_addr[5:2]];
                        wr_rd = 1'b1;
                    end
                end
            end
            7'b0100011: begin
                if (f3 == 3'b010) begin
                    exp_mem = 1'b1;
                    exp_addr = a + s_imm;
                    exp_wdata = b;
                    exp_we = (exp_addr[1:0] == 2'b00);
                    if (exp_we) begin
                        ref_mem[exp_addr[5:2]] = b;
                    end
                end
            end
            7'b1100011: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    3'b111: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                tgt = ref_pc + b_imm;
                if (taken && !tgt[1]) begin
                    next_pc = tgt;
                end
            end
            7'b1101111: begin
                tgt = ref_pc + j_imm;
                if (!tgt[1]) begin
                    next_pc = tgt;
                    res = ref_pc + 32'd4;
                    wr_rd = 1'b1;
                end
            end
            7'b1100111: begin
                tgt = (a + i_imm) & ~32'd1;
                if (f3 == 3'b000 && !tgt[1]) begin
                    next_pc = tgt;
                    res = ref_pc + 32'd4;
                    wr_rd = 1'b1;
                end
            end
            default: begin
                // Unknown opcode only moves on
                next_pc = ref_pc + 32'd4;
            end
        endcase
        if (wr_rd && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = res;
        end
        ref_pc = next_pc;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] w;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3, bf3, kind;
        logic        observe;
        // Directed fill of every register followed by a store of each
        for (int k = 1; k < 32; k++) begin
            r = random_bits(12);
            prog.push_back({r[11:0], 5'd0, 3'b000, 5'(k), 7'b0010011});
        end
        for (int k = 1; k < 32; k++) begin
            prog.push_back(store_of(5'(k)));
        end
        for (int n = 0; n < random_ops; n++) begin
            r = random_bits(32);
            s = random_bits(21);
            kind = s[2:0];
            rd = s[7:3];
            rs1 = s[12:8];
            rs2 = s[17:13];
            f3 = s[20:18];
            bf3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
            observe = 1'b1;
            case (kind)
                3'd0, 3'd1: begin
                    w = {1'b0, r[31] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                         rs2, rs1, f3, rd, 7'b0110011};
                end
                3'd2: begin
                    case (f3)
                        3'b001: w = {7'b0, r[4:0], rs1, f3, rd, 7'b0010011};
                        3'b101: w = {1'b0, r[31], 5'b0, r[4:0], rs1, f3, rd, 7'b0010011};
                        default: w = {r[11:0], rs1, f3, rd, 7'b0010011};
                    endcase
                end
                3'd3: w = {r[31:12], rd, r[0] ? 7'b0110111 : 7'b0010111};
                3'd4: begin
                    case (r[31:30])
                        2'b10: w = {r[20], r[10:1], r[11], r[19:12], rd, 7'b1101111};
                        2'b11: w = {r[11:0], rs1, 3'b000, rd, 7'b1100111};
                        default: begin
                            w = {r[12], r[10:5], rs2, rs1, bf3, r[4:1], r[11], 7'b1100011};
                            observe = 1'b0;
                        end
                    endcase
                end
                3'd5: begin
                    // Half the loads use x0 so the address is aligned
                    w = r[31] ? {r[11:2], 2'b00, 5'd0, 3'b010, rd, 7'b0000011} :
                                {r[11:0], rs1, 3'b010, rd, 7'b0000011};
                end
                3'd6: begin
                    w = r[31] ? {r[11:5], rs2, 5'd0, 3'b010, r[4:2], 2'b00, 7'b0100011} :
                                {r[11:5], rs2, rs1, 3'b010, r[4:0], 7'b0100011};
                    observe = 1'b0;
                end
                default: begin
                    w = (r[30:28] == 3'b000) ? {r[31:7], 7'b0001011} :
                                               {r[11:0], rs1, 3'b000, rd, 7'b0010011};
                end
            endcase
            prog.push_back(w);
            if (observe) begin
                prog.push_back(store_of(rd));
            end
        end
        // Trailing nop shows the last next-PC
        prog.push_back(32'h00000013);
    endtask

    // Stimulus
    initial begin
        // A store of x1 held during reset must not write
        instr = 32'h00102023;
        ref_pc = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            dmem[i] = 32'h9e3779b9 * (i + 1);
            ref_mem[i] = dmem[i];
        end
        build_program();
        prog_ready = 1'b1;
        wait (reset === 1'b0);
        running = 1'b1;
        foreach (prog[k]) begin
            if (k > 0) begin
                @(posedge clk);
                #drive_delay;
            end
            instr = prog[k];
        end
        @(posedge clk);
        #drive_delay;
        running = 1'b0;
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // Compare at the falling edge when all outputs have settled
    initial begin
        logic [31:0] exp_pc;
        logic [31:0] exp_addr;
        logic [31:0] exp_wdata;
        logic        exp_mem;
        logic        exp_we;
        @(negedge clk);
        forever begin
            if (reset) begin
                compare_value("pc in reset", pc, 32'd0);
                compare_value("wr_en in reset", {31'b0, wr_en}, 32'd0);
            end else if (running) begin
                execute_ref(instr, exp_pc, exp_mem, exp_we, exp_addr, exp_wdata);
                compare_value("pc", pc, exp_pc);
                compare_value("wr_en", {31'b0, wr_en}, {31'b0, exp_we});
                if (exp_mem) begin
                    compare_value("addr", addr, exp_addr);
                end
                if (exp_we) begin
                    compare_value("wr_data", wr_data, exp_wdata);
                end
            end
            @(negedge clk);
        end
    end

    // Watchdog sized from the program length plus reset and margin
    initial begin
        longint limit;
        wait (prog_ready);
        limit = (prog.size() + 13) * period_ns;
        #(limit);
        $display("watchdog expired after %0d ns before the test finished", limit);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

/* testbench/rv_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pc,
    input logic [31:0] addr,
    input logic        wr_en
);

    // No store may leave the core while it is held in reset
    store_blocked_in_reset: assert property (@(posedge clk) reset |-> !wr_en)
        else $error("wr_en is high while reset is high");

    store_word_aligned: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (addr[1:0] == 2'b00)
    ) else $error("store issued to an address that is not word aligned");

    // Misaligned targets never reach the PC
    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int period_ns   = 100;
    localparam int reset_edges = 3;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Released shortly after the third rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_edges) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] rd_data,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] addr,
    output logic [xlen-1:0] wr_data,
    output logic            wr_en
);

    instr_word_t         iw;
    logic [alu_op_w-1:0] alu_op;
    logic [2:0]          imm_fmt;
    logic                src1_pc;
    logic                src2_imm;
    logic [1:0]          pc_sel;
    logic [1:0]          wb_sel;
    logic                rf_wr_en;
    logic                branch_flag;
    logic                target_bit1;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
    logic [xlen-1:0]     op_a;
    logic [xlen-1:0]     op_b;
    logic [xlen-1:0]     alu_result;
    logic [xlen-1:0]     pc_plus4;
    logic [xlen-1:0]     rd_wdata;

    assign iw.raw = instr;

    // Operand selects
    assign op_a = src1_pc ? pc : rs1_data;
    assign op_b = src2_imm ? imm : rs2_data;

    // Write-back select
    assign rd_wdata = (wb_sel == wb_mem)  ? rd_data :
                      (wb_sel == wb_link) ? pc_plus4 :
                      (wb_sel == wb_imm)  ? imm : alu_result;

    assign addr    = alu_result;
    assign wr_data = rs2_data;

    rv_decoder u_decoder (
        .reset(reset), .instr(iw), .alu_low(alu_result[1:0]), .branch_flag(branch_flag),
        .target_bit1(target_bit1), .alu_op(alu_op), .imm_fmt(imm_fmt), .src1_pc(src1_pc),
        .src2_imm(src2_imm), .pc_sel(pc_sel), .wb_sel(wb_sel), .rf_wr_en(rf_wr_en),
        .wr_en(wr_en)
    );

    rv_imm_gen u_imm_gen (.instr(iw), .imm_fmt(imm_fmt), .imm(imm));

    rv_alu u_alu (
        .op_a(op_a), .op_b(op_b), .alu_op(alu_op), .result(alu_result),
        .branch_flag(branch_flag)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1(iw.r.rs1), .rs2(iw.r.rs2), .rd(iw.r.rd), .wr_en(rf_wr_en),
        .rd_wdata(rd_wdata), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_pc_unit u_pc_unit (
        .clk(clk), .reset(reset), .imm(imm), .alu_result(alu_result), .pc_sel(pc_sel),
        .pc(pc), .pc_plus4(pc_plus4), .target_bit1(target_bit1)
    );

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
    input  logic                reset,
    input  instr_word_t         instr,
    input  logic [1:0]          alu_low,
    input  logic                branch_flag,
    input  logic                target_bit1,
    output logic [alu_op_w-1:0] alu_op,
    output logic [2:0]          imm_fmt,
    output logic                src1_pc,
    output logic                src2_imm,
    output logic [1:0]          pc_sel,
    output logic [1:0]          wb_sel,
    output logic                rf_wr_en,
    output logic                wr_en
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       word_aligned;
    logic       taken;

    // Opcode forced to zero in reset so nothing is written
    assign opcode = reset ? 7'b0 : instr.r.opcode;
    assign funct3 = instr.r.funct3;

    // Selects sub and sra
    assign alt = instr.r.funct7[5];

    assign word_aligned = (alu_low == 2'b00);

    // Compare flag inverted by funct3[0] for bne, bge, bgeu
    assign taken = branch_flag ^ funct3[0];

    always_comb begin
        alu_op   = alu_add;
        imm_fmt  = imm_i;
        src1_pc  = 1'b0;
        src2_imm = 1'b0;
        pc_sel   = pc_seq;
        wb_sel   = wb_alu;
        rf_wr_en = 1'b0;
        wr_en    = 1'b0;

        case (opcode)
            op_load: begin
                if (funct3 == 3'b010) begin
                    src2_imm = 1'b1;
                    wb_sel   = wb_mem;
                    rf_wr_en = word_aligned;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    imm_fmt  = imm_s;
                    src2_imm = 1'b1;
                    wr_en    = word_aligned;
                end
            end
            op_imm: begin
                // No subtract form among the immediates
                alu_op   = {alt & (funct3 == 3'b101), funct3};
                src2_imm = 1'b1;
                rf_wr_en = 1'b1;
            end
            op_arith: begin
                alu_op   = {alt & (funct3 == 3'b000 || funct3 == 3'b101), funct3};
                rf_wr_en = 1'b1;
            end
            op_lui: begin
                imm_fmt  = imm_u;
                wb_sel   = wb_imm;
                rf_wr_en = 1'b1;
            end
            op_auipc: begin
                imm_fmt  = imm_u;
                src1_pc  = 1'b1;
                src2_imm = 1'b1;
                rf_wr_en = 1'b1;
            end
            op_branch: begin
                imm_fmt = imm_b;
                alu_op  = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
                // Funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01 && taken && !target_bit1) begin
                    pc_sel = pc_target;
                end
            end
            op_jal: begin
                imm_fmt = imm_j;
                wb_sel  = wb_link;
                if (!target_bit1) begin
                    pc_sel   = pc_target;
                    rf_wr_en = 1'b1;
                end
            end
            op_jalr: begin
                src2_imm = 1'b1;
                wb_sel   = wb_link;
                // Target bit 0 is cleared later so bit 1 decides alignment
                if (funct3 == 3'b000 && !alu_low[1]) begin
                    pc_sel   = pc_alu;
                    rf_wr_en = 1'b1;
                end
            end
            default: begin
                // Unknown opcode, PC just advances
                pc_sel = pc_seq;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_result,
    input  logic [1:0]      pc_sel,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus4,
    output logic            target_bit1
);

    logic [xlen-1:0] target;
    logic [xlen-1:0] next_pc;

    assign pc_plus4    = pc + 32'd4;
    assign target      = pc + imm;
    assign target_bit1 = target[1];

    always_comb begin
        case (pc_sel)
            pc_target: next_pc = target;
            // JALR target with bit 0 cleared
            pc_alu:    next_pc = {alu_result[xlen-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  wr_en,
    input  logic [xlen-1:0]       rd_wdata,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wr_en && rd != '0) begin
            regs[rd] <= rd_wdata;
        end
    end

    // Combinational reads, x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/rv_imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_core_pkg::*; (
    input  instr_word_t     instr,
    input  logic [2:0]      imm_fmt,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            imm_s: begin
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            imm_b: begin
                // B layout shares the S fields, bit 11 moved to imm_lo[0]
                imm = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                       instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
            end
            imm_u: begin
                imm = {instr.u.imm, 12'b0};
            end
            imm_j: begin
                // J layout scrambles the U field
                imm = {{11{instr.u.imm[19]}}, instr.u.imm[19], instr.u.imm[7:0],
                       instr.u.imm[8], instr.u.imm[18:9], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
    input  logic [xlen-1:0]     op_a,
    input  logic [xlen-1:0]     op_b,
    input  logic [alu_op_w-1:0] alu_op,
    output logic [xlen-1:0]     result,
    output logic                branch_flag
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        branch_flag = 1'b0;
        case (alu_op)
            alu_add:  result = op_a + op_b;
            alu_sub: begin
                result      = op_a - op_b;
                // Equality for beq and bne
                branch_flag = (op_a == op_b);
            end
            alu_sll:  result = op_a << shamt;
            alu_slt: begin
                result      = {{(xlen-1){1'b0}}, lt_signed};
                branch_flag = lt_signed;
            end
            alu_sltu: begin
                result      = {{(xlen-1){1'b0}}, lt_unsigned};
                branch_flag = lt_unsigned;
            end
            alu_xor:  result = op_a ^ op_b;
            alu_srl:  result = op_a >> shamt;
            alu_sra:  result = $signed(op_a) >>> shamt;
            alu_or:   result = op_a | op_b;
            alu_and:  result = op_a & op_b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 4;

    // Base opcodes in instr[6:0]
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_arith  = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // Funct3 sits in the low bits, bit 3 marks sub and sra
    localparam logic [alu_op_w-1:0] alu_add  = 4'b0000;
    localparam logic [alu_op_w-1:0] alu_sub  = 4'b1000;
    localparam logic [alu_op_w-1:0] alu_sll  = 4'b0001;
    localparam logic [alu_op_w-1:0] alu_slt  = 4'b0010;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'b0011;
    localparam logic [alu_op_w-1:0] alu_xor  = 4'b0100;
    localparam logic [alu_op_w-1:0] alu_srl  = 4'b0101;
    localparam logic [alu_op_w-1:0] alu_sra  = 4'b1101;
    localparam logic [alu_op_w-1:0] alu_or   = 4'b0110;
    localparam logic [alu_op_w-1:0] alu_and  = 4'b0111;

    // Immediate formats
    localparam logic [2:0] imm_i = 3'd0;
    localparam logic [2:0] imm_s = 3'd1;
    localparam logic [2:0] imm_b = 3'd2;
    localparam logic [2:0] imm_u = 3'd3;
    localparam logic [2:0] imm_j = 3'd4;

    // Next-PC sources
    localparam logic [1:0] pc_seq    = 2'd0;
    localparam logic [1:0] pc_target = 2'd1;
    localparam logic [1:0] pc_alu    = 2'd2;

    // Register write-back sources
    localparam logic [1:0] wb_alu  = 2'd0;
    localparam logic [1:0] wb_mem  = 2'd1;
    localparam logic [1:0] wb_link = 2'd2;
    localparam logic [1:0] wb_imm  = 2'd3;

    // One instruction word seen through each encoding layout
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instr_word_t;

endpackage

`default_nettype wire
